//--- bench/bank_mem_sva.sv
// Crossbar protocol checks; bound into bank_xbar, flags lane and bank handshake violations
`timescale 1ns/1ps

module bank_mem_sva import bank_mem_pkg::*; (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic      [LANES-1:0]     wr_req_i,
  input logic      [LANES-1:0]     wr_gnt_i,
  input bank_sel_t [LANES-1:0]     wr_bank_sel_i,
  input logic      [LANES-1:0]     rd_req_i,
  input logic      [LANES-1:0]     rd_gnt_i,
  input bank_sel_t [LANES-1:0]     rd_bank_sel_i,
  input logic      [LANES-1:0]     rd_rvalid_i,
  input logic      [NUM_BANKS-1:0] mem_req_i,
  input logic      [NUM_BANKS-1:0] mem_gnt_i,
  input logic      [NUM_BANKS-1:0] mem_we_i,
  input mem_addr_t [NUM_BANKS-1:0] mem_addr_i,
  input mem_data_t [NUM_BANKS-1:0] mem_wdata_i,
  input mem_strb_t [NUM_BANKS-1:0] mem_be_i
);

  // Count of failed protocol checks
  int unsigned fail_count = 0;

  for (genvar j = 0; j < LANES; j++) begin : gen_lane
    // Unit lanes keep asking until granted
    a_wr_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wr_req_i[j] && !wr_gnt_i[j]) |=> wr_req_i[j])
      else begin
        fail_count++;
        $error("write lane %0d dropped its request before the grant", j);
      end
    a_rd_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (rd_req_i[j] && !rd_gnt_i[j]) |=> rd_req_i[j])
      else begin
        fail_count++;
        $error("read lane %0d dropped its request before the grant", j);
      end

    // A read grant on this lane returns data after exactly the read latency
    a_rvalid_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rd_gnt_i[j] |-> ##MEM_LATENCY rd_rvalid_i[j])
      else begin
        fail_count++;
        $error("read lane %0d grant gave no rvalid after the read latency", j);
      end

    // No read data without a read grant one latency earlier
    a_rvalid_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rd_rvalid_i[j] |-> $past(rd_gnt_i[j], MEM_LATENCY))
      else begin
        fail_count++;
        $error("read lane %0d rvalid without a read grant before it", j);
      end

    // Granted write and read lanes never point at the same bank
    for (genvar k = 0; k < LANES; k++) begin : gen_pair
      a_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_gnt_i[j] && rd_gnt_i[k]) |-> (wr_bank_sel_i[j] != rd_bank_sel_i[k]))
        else begin
          fail_count++;
          $error("write lane %0d and read lane %0d granted the same bank", j, k);
        end
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    // Stalled bank sees the same request next cycle
    a_bank_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (mem_req_i[b] && !mem_gnt_i[b]) |=> (mem_req_i[b] && $stable(mem_addr_i[b]) &&
        $stable(mem_we_i[b]) && $stable(mem_wdata_i[b]) && $stable(mem_be_i[b])))
      else begin
        fail_count++;
        $error("bank %0d request changed while waiting for its grant", b);
      end
  end

endmodule

bind bank_xbar bank_mem_sva i_sva (
  .clk_i         ( clk_i           ),
  .rst_n_i       ( rst_n_i         ),
  .wr_req_i      ( wr_bus.req      ),
  .wr_gnt_i      ( wr_bus.gnt      ),
  .wr_bank_sel_i ( wr_bus.bank_sel ),
  .rd_req_i      ( rd_bus.req      ),
  .rd_gnt_i      ( rd_bus.gnt      ),
  .rd_bank_sel_i ( rd_bus.bank_sel ),
  .rd_rvalid_i   ( rd_bus.rvalid   ),
  .mem_req_i     ( mem_req_o       ),
  .mem_gnt_i     ( mem_gnt_i       ),
  .mem_we_i      ( mem_we_o        ),
  .mem_addr_i    ( mem_addr_o      ),
  .mem_wdata_i   ( mem_wdata_o     ),
  .mem_be_i      ( mem_be_o        )
);

//--- bench/tb_bank_mem.sv
// Bench top for the banked memory slave; SRAM model, bus stimulus, reference model and checks
`timescale 1ns/1ps

module tb_bank_mem import bank_mem_pkg::*; ();

  logic clk;
  logic rst_n;

  // Bus side
  logic      wr_valid;
  logic      wr_ready;
  bus_addr_t wr_addr;
  bus_data_t wr_data;
  bus_strb_t wr_strb;
  logic      wr_bvalid;
  logic      wr_bready;
  logic      rd_valid;
  logic      rd_ready;
  bus_addr_t rd_addr;
  logic      rd_rvalid;
  bus_data_t rd_rdata;
  logic      rd_rready;

  // Bank side
  logic      [NUM_BANKS-1:0] mem_req;
  logic      [NUM_BANKS-1:0] mem_gnt;
  mem_addr_t [NUM_BANKS-1:0] mem_addr;
  logic      [NUM_BANKS-1:0] mem_we;
  mem_data_t [NUM_BANKS-1:0] mem_wdata;
  mem_strb_t [NUM_BANKS-1:0] mem_be;
  mem_data_t [NUM_BANKS-1:0] mem_rdata;

  // SRAM contents and expected 64-bit words, indexed by address bits 9:3
  mem_data_t sram [NUM_BANKS][2**MEM_ADDR_WIDTH];
  bus_data_t ref_mem [128];
  logic [6:0] rd_index;
  bus_data_t  exp_rdata;

  int unsigned data_errors    = 0;
  int unsigned check_errors   = 0;
  int unsigned timeout_errors = 0;
  int unsigned cycles         = 0;

  tb_clock_gen i_clock_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  bank_mem_top i_dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .wr_valid_i  ( wr_valid  ),
    .wr_ready_o  ( wr_ready  ),
    .wr_addr_i   ( wr_addr   ),
    .wr_data_i   ( wr_data   ),
    .wr_strb_i   ( wr_strb   ),
    .wr_bvalid_o ( wr_bvalid ),
    .wr_bready_i ( wr_bready ),
    .rd_valid_i  ( rd_valid  ),
    .rd_ready_o  ( rd_ready  ),
    .rd_addr_i   ( rd_addr   ),
    .rd_rvalid_o ( rd_rvalid ),
    .rd_rdata_o  ( rd_rdata  ),
    .rd_rready_i ( rd_rready ),
    .mem_req_o   ( mem_req   ),
    .mem_gnt_i   ( mem_gnt   ),
    .mem_addr_o  ( mem_addr  ),
    .mem_we_o    ( mem_we    ),
    .mem_wdata_o ( mem_wdata ),
    .mem_be_o    ( mem_be    ),
    .mem_rdata_i ( mem_rdata )
  );

  // Start value of a 32-bit word, built from its 10-bit byte address
  function automatic mem_data_t fill_word(input logic [9:0] byte_addr);
    return {6'h2b, byte_addr, 6'h15, byte_addr};
  endfunction

  // Bus address from alias bits 15:10, row 9:4 and bank pair bit 3
  function automatic bus_addr_t build_addr(input logic [5:0] upper, input logic [5:0] row,
                                           input logic pair);
    return {upper, row, pair, 3'b000};
  endfunction

  // Random grant per bank, three in four cycles
  task automatic drive_grants();
    forever begin
      @(negedge clk);
      for (int b = 0; b < NUM_BANKS; b++) begin
        mem_gnt[b] = ($urandom % 4) != 0;
      end
    end
  endtask

  // SRAM banks with byte enables, read data one cycle after the grant
  always @(posedge clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (mem_req[b] && mem_gnt[b]) begin
        if (mem_we[b]) begin
          for (int k = 0; k < MEM_STRB_WIDTH; k++) begin
            if (mem_be[b][k]) begin
              sram[b][mem_addr[b]][8*k +: 8] <= mem_wdata[b][8*k +: 8];
            end
          end
        end else begin
          mem_rdata[b] <= sram[b][mem_addr[b]];
        end
      end
    end
  end

  // Reference takes each write when it is accepted
  always @(posedge clk) begin
    if (rst_n && wr_valid && wr_ready) begin
      for (int k = 0; k < BUS_STRB_WIDTH; k++) begin
        if (wr_strb[k]) begin
          ref_mem[wr_addr[9:3]][8*k +: 8] <= wr_data[8*k +: 8];
        end
      end
    end
    if (rd_valid && rd_ready) begin
      rd_index <= rd_addr[9:3];
    end
  end

  assign exp_rdata = ref_mem[rd_index];

  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_rvalid && rd_rready) |-> (rd_rdata == exp_rdata))
    else begin
      data_errors++;
      $display("** Error at time %0t: rd_rdata_o = 0x%h, expected 0x%h",
               $time, $sampled(rd_rdata), $sampled(exp_rdata));
    end

  // Idle outputs on the cycle after any reset edge
  a_reset_idle: assert property (@(posedge clk)
    !rst_n |=> (!wr_bvalid && !rd_rvalid && (mem_req == '0) && wr_ready && rd_ready))
    else begin
      check_errors++;
      $display("Outputs were not idle after reset at time %0t", $time);
    end

  a_wr_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_bvalid && !wr_bready) |=> (wr_bvalid && !wr_ready))
    else begin
      check_errors++;
      $display("Write response not held under back-pressure at time %0t", $time);
    end

  a_rd_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_rvalid && !rd_rready) |=> (rd_rvalid && !rd_ready && $stable(rd_rdata)))
    else begin
      check_errors++;
      $display("Read response not held under back-pressure at time %0t", $time);
    end

  // One write, stall = cycles with bready held low once bvalid shows
  task automatic write_access(input bus_addr_t addr, input bus_data_t data,
                              input bus_strb_t strb, input int unsigned stall);
    wr_addr  = addr;
    wr_data  = data;
    wr_strb  = strb;
    wr_valid = 1'b1;
    while (!wr_ready) @(negedge clk);
    @(negedge clk);
    wr_valid = 1'b0;
    while (!wr_bvalid) @(negedge clk);
    repeat (stall) @(negedge clk);
    wr_bready = 1'b1;
    @(negedge clk);
    wr_bready = 1'b0;
  endtask

  task automatic read_access(input bus_addr_t addr, input int unsigned stall);
    rd_addr  = addr;
    rd_valid = 1'b1;
    while (!rd_ready) @(negedge clk);
    @(negedge clk);
    rd_valid = 1'b0;
    while (!rd_rvalid) @(negedge clk);
    repeat (stall) @(negedge clk);
    rd_rready = 1'b1;
    @(negedge clk);
    rd_rready = 1'b0;
  endtask

  // Writes to rows whose low bit equals parity, random aliases and strobes
  task automatic random_writes(input logic pair, input logic parity, input int unsigned count);
    bus_addr_t addr;
    for (int unsigned i = 0; i < count; i++) begin
      addr = build_addr(6'($urandom), {5'($urandom), parity}, pair);
      write_access(addr, {$urandom, $urandom}, 8'($urandom), $urandom_range(3, 0));
    end
  endtask

  task automatic random_reads(input logic pair, input logic parity, input int unsigned count);
    bus_addr_t addr;
    for (int unsigned i = 0; i < count; i++) begin
      addr = build_addr(6'($urandom), {5'($urandom), parity}, pair);
      read_access(addr, $urandom_range(3, 0));
    end
  endtask

  task automatic report_and_finish();
    int unsigned bank_errors;
    bank_errors = i_dut.i_xbar.i_sva.fail_count;
    $display("Errors: rdata %0d, protocol %0d, bank %0d, timeout %0d",
             data_errors, check_errors, bank_errors, timeout_errors);
    if (data_errors + check_errors + bank_errors + timeout_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // About 330 accesses at up to 10 cycles each, with margin
  always @(posedge clk) begin
    cycles++;
    if (cycles == 4000) begin
      timeout_errors++;
      $display("Timeout: run did not finish within 4000 cycles");
      report_and_finish();
    end
  end

  initial begin
    void'($urandom(32'h66e3_7b3b));
    wr_valid  = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    wr_strb   = '0;
    wr_bready = 1'b0;
    rd_valid  = 1'b0;
    rd_addr   = '0;
    rd_rready = 1'b0;
    mem_gnt   = '0;
    mem_rdata = '0;
    rd_index  = '0;
    // Grant pattern follows the seed above
    fork
      drive_grants();
    join_none
    // Bank b row r holds the word at byte address {r, b, 00}
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r < 2**MEM_ADDR_WIDTH; r++) begin
        sram[b][r] = fill_word(10'((r << 4) | (b << 2)));
      end
    end
    for (int i = 0; i < 128; i++) begin
      ref_mem[i] = {fill_word(10'((i << 3) | 4)), fill_word(10'(i << 3))};
    end
    @(posedge rst_n);
    @(negedge clk);
    // Full word write and read back
    write_access(16'h0040, 64'h0123_4567_89ab_cdef, 8'hff, 0);
    read_access(16'h0040, 0);
    // Partial strobes merge into the start value, with stalled responses
    write_access(16'h0048, 64'hdead_beef_cafe_f00d, 8'h5a, 2);
    read_access(16'h0048, 3);
    write_access(16'h0048, 64'h1111_2222_3333_4444, 8'h81, 1);
    read_access(16'h0048, 0);
    // Upper bits 15:10 alias onto the same row
    write_access(16'hfc80, 64'h0f0f_a5a5_5a5a_f0f0, 8'hff, 0);
    read_access(16'h0480, 1);
    // Both units on one bank pair, reads never on the rows being written
    for (int p = 0; p < 2; p++) begin
      fork
        random_writes(p[0], 1'b0, 40);
        random_reads(p[0], 1'b1, 40);
      join
      fork
        random_writes(p[0], 1'b1, 40);
        random_reads(p[0], 1'b0, 40);
      join
    end
    repeat (5) @(negedge clk);
    report_and_finish();
  end

endmodule

//--- bench/tb_clock_gen.sv
// Bench clock and reset source; free-running 20 ns clock, reset low for the first 10 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Half period of 10 ns
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release on a falling edge, like all other bench inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- flist.f
verilog/bank_mem_pkg.sv
verilog/bank_req_if.sv
verilog/bank_wr_unit.sv
verilog/bank_rd_unit.sv
verilog/bank_xbar.sv
verilog/bank_mem_top.sv
bench/tb_clock_gen.sv
bench/bank_mem_sva.sv
bench/tb_bank_mem.sv

//--- verilog/bank_mem_pkg.sv
// Shared widths, read latency and FSM state types; imported by every RTL module and the bench
package bank_mem_pkg;

  // Bus side, one 64-bit beat per access
  localparam int unsigned BUS_ADDR_WIDTH  = 16;
  localparam int unsigned BUS_DATA_WIDTH  = 64;
  localparam int unsigned BUS_STRB_WIDTH  = BUS_DATA_WIDTH / 8;

  // Bank side, 32-bit SRAM words
  localparam int unsigned MEM_DATA_WIDTH  = 32;
  localparam int unsigned MEM_STRB_WIDTH  = MEM_DATA_WIDTH / 8;
  localparam int unsigned NUM_BANKS       = 4;
  // Banks touched by one bus beat
  localparam int unsigned LANES           = BUS_DATA_WIDTH / MEM_DATA_WIDTH;

  // Byte address bits 3:2 pick the bank, bits 9:4 the row
  localparam int unsigned BANK_SEL_OFFSET = 2;
  localparam int unsigned BANK_SEL_WIDTH  = 2;
  localparam int unsigned MEM_ADDR_WIDTH  = 6;

  // Cycles from a granted read to valid rdata
  localparam int unsigned MEM_LATENCY     = 1;

  typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;
  typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;
  typedef logic [BUS_STRB_WIDTH-1:0] bus_strb_t;
  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [MEM_DATA_WIDTH-1:0] mem_data_t;
  typedef logic [MEM_STRB_WIDTH-1:0] mem_strb_t;
  typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;

  // Unit a bank was last given to, decides the next contested grant
  typedef enum logic {
    OWNER_RD = 1'b0,
    OWNER_WR = 1'b1
  } owner_e;

  typedef enum logic [1:0] {WR_IDLE, WR_ISSUE, WR_RESP} wr_state_e;

  typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_WAIT, RD_RESP} rd_state_e;

endpackage

//--- verilog/bank_mem_top.sv
// Top of the banked memory slave; bus ports to the two units, bank ports to the crossbar
`timescale 1ns/1ps

module bank_mem_top import bank_mem_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Write request and response
  input  logic                      wr_valid_i,
  output logic                      wr_ready_o,
  input  bus_addr_t                 wr_addr_i,
  input  bus_data_t                 wr_data_i,
  input  bus_strb_t                 wr_strb_i,
  output logic                      wr_bvalid_o,
  input  logic                      wr_bready_i,
  // Read request and response
  input  logic                      rd_valid_i,
  output logic                      rd_ready_o,
  input  bus_addr_t                 rd_addr_i,
  output logic                      rd_rvalid_o,
  output bus_data_t                 rd_rdata_o,
  input  logic                      rd_rready_i,
  // SRAM banks
  output logic      [NUM_BANKS-1:0] mem_req_o,
  input  logic      [NUM_BANKS-1:0] mem_gnt_i,
  output mem_addr_t [NUM_BANKS-1:0] mem_addr_o,
  output logic      [NUM_BANKS-1:0] mem_we_o,
  output mem_data_t [NUM_BANKS-1:0] mem_wdata_o,
  output mem_strb_t [NUM_BANKS-1:0] mem_be_o,
  input  mem_data_t [NUM_BANKS-1:0] mem_rdata_i
);

  // Lane links, unit side to crossbar
  bank_req_if wr_bus ();
  bank_req_if rd_bus ();

  bank_wr_unit i_wr_unit (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .wr_valid_i  ( wr_valid_i  ),
    .wr_ready_o  ( wr_ready_o  ),
    .wr_addr_i   ( wr_addr_i   ),
    .wr_data_i   ( wr_data_i   ),
    .wr_strb_i   ( wr_strb_i   ),
    .wr_bvalid_o ( wr_bvalid_o ),
    .wr_bready_i ( wr_bready_i ),
    .wr_bus      ( wr_bus.unit )
  );

  bank_rd_unit i_rd_unit (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rd_valid_i  ( rd_valid_i  ),
    .rd_ready_o  ( rd_ready_o  ),
    .rd_addr_i   ( rd_addr_i   ),
    .rd_rvalid_o ( rd_rvalid_o ),
    .rd_rdata_o  ( rd_rdata_o  ),
    .rd_rready_i ( rd_rready_i ),
    .rd_bus      ( rd_bus.unit )
  );

  bank_xbar i_xbar (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .wr_bus      ( wr_bus.xbar ),
    .rd_bus      ( rd_bus.xbar ),
    .mem_req_o   ( mem_req_o   ),
    .mem_gnt_i   ( mem_gnt_i   ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_we_o    ( mem_we_o    ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_be_o    ( mem_be_o    ),
    .mem_rdata_i ( mem_rdata_i )
  );

endmodule

//--- verilog/bank_rd_unit.sv
// Read unit; takes one 64-bit read, fetches both lanes from the banks, returns the joined word
`timescale 1ns/1ps

module bank_rd_unit import bank_mem_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      rd_valid_i,
  output logic      rd_ready_o,
  input  bus_addr_t rd_addr_i,
  output logic      rd_rvalid_o,
  output bus_data_t rd_rdata_o,
  input  logic      rd_rready_i,
  bank_req_if.unit  rd_bus
);

  rd_state_e        state_q, state_d;
  // Per lane, request granted
  logic [LANES-1:0] done_q, done_d;
  // Per lane, read data captured
  logic [LANES-1:0] got_q, got_d;
  logic             collect;
  bus_addr_t        addr_q;
  bus_data_t        rdata_q;

  assign rd_ready_o  = (state_q == RD_IDLE);
  assign rd_rvalid_o = (state_q == RD_RESP);
  assign rd_rdata_o  = rdata_q;

  // Data of an early lane may come back while the other still waits for a grant
  assign collect = (state_q == RD_ISSUE) || (state_q == RD_WAIT);

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      rd_bus.req[j]      = (state_q == RD_ISSUE) && !done_q[j];
      rd_bus.bank_sel[j] = {addr_q[BANK_SEL_OFFSET+BANK_SEL_WIDTH-1], j[0]};
      rd_bus.addr[j]     = addr_q[BANK_SEL_OFFSET+BANK_SEL_WIDTH +: MEM_ADDR_WIDTH];
      // Read only, write payload tied off
      rd_bus.we[j]       = 1'b0;
      rd_bus.wdata[j]    = '0;
      rd_bus.strb[j]     = '0;
    end
  end

  always_comb begin
    state_d = state_q;
    done_d  = done_q;
    got_d   = got_q;
    if (collect) begin
      got_d = got_q | rd_bus.rvalid;
    end
    case (state_q)
      RD_IDLE: begin
        if (rd_valid_i) begin
          state_d = RD_ISSUE;
          done_d  = '0;
          got_d   = '0;
        end
      end
      RD_ISSUE: begin
        done_d = done_q | (rd_bus.req & rd_bus.gnt);
        // Last grant always returns data at least one cycle later
        if (&done_d) begin
          state_d = RD_WAIT;
        end
      end
      RD_WAIT: begin
        if (&got_d) begin
          state_d = RD_RESP;
        end
      end
      RD_RESP: begin
        // Hold data until the bus takes it
        if (rd_rready_i) begin
          state_d = RD_IDLE;
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= RD_IDLE;
      done_q  <= '0;
      got_q   <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      got_q   <= got_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_i && rd_ready_o) begin
      addr_q <= rd_addr_i;
    end
  end

  // Lane 0 fills the low half
  always_ff @(posedge clk_i) begin
    for (int j = 0; j < LANES; j++) begin
      if (collect && rd_bus.rvalid[j]) begin
        rdata_q[j*MEM_DATA_WIDTH +: MEM_DATA_WIDTH] <= rd_bus.rdata[j];
      end
    end
  end

endmodule

//--- verilog/bank_req_if.sv
// Two-lane bank request and read return between one access unit and the bank crossbar
`timescale 1ns/1ps

interface bank_req_if import bank_mem_pkg::*; ();

  // Request side, one entry per 32-bit lane
  logic      [LANES-1:0] req;
  logic      [LANES-1:0] gnt;
  bank_sel_t [LANES-1:0] bank_sel;
  mem_addr_t [LANES-1:0] addr;
  logic      [LANES-1:0] we;
  mem_data_t [LANES-1:0] wdata;
  mem_strb_t [LANES-1:0] strb;

  // Read return, pulses MEM_LATENCY cycles after a read grant
  logic      [LANES-1:0] rvalid;
  mem_data_t [LANES-1:0] rdata;

  // Access unit end
  modport unit (
    output req, bank_sel, addr, we, wdata, strb,
    input  gnt, rvalid, rdata
  );

  // Crossbar end
  modport xbar (
    input  req, bank_sel, addr, we, wdata, strb,
    output gnt, rvalid, rdata
  );

endinterface

//--- verilog/bank_wr_unit.sv
// Write unit; takes one strobed 64-bit write, splits it over two bank lanes, then answers
`timescale 1ns/1ps

module bank_wr_unit import bank_mem_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      wr_valid_i,
  output logic      wr_ready_o,
  input  bus_addr_t wr_addr_i,
  input  bus_data_t wr_data_i,
  input  bus_strb_t wr_strb_i,
  output logic      wr_bvalid_o,
  input  logic      wr_bready_i,
  bank_req_if.unit  wr_bus
);

  wr_state_e        state_q, state_d;
  logic [LANES-1:0] done_q, done_d;
  bus_addr_t        addr_q;
  bus_data_t        data_q;
  bus_strb_t        strb_q;

  // Only idle takes a new write
  assign wr_ready_o  = (state_q == WR_IDLE);
  assign wr_bvalid_o = (state_q == WR_RESP);

  // Lane j carries the j-th 32-bit half, bank low select bit equals lane
  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      wr_bus.req[j]      = (state_q == WR_ISSUE) && !done_q[j];
      wr_bus.bank_sel[j] = {addr_q[BANK_SEL_OFFSET+BANK_SEL_WIDTH-1], j[0]};
      wr_bus.addr[j]     = addr_q[BANK_SEL_OFFSET+BANK_SEL_WIDTH +: MEM_ADDR_WIDTH];
      wr_bus.we[j]       = 1'b1;
      wr_bus.wdata[j]    = data_q[j*MEM_DATA_WIDTH +: MEM_DATA_WIDTH];
      wr_bus.strb[j]     = strb_q[j*MEM_STRB_WIDTH +: MEM_STRB_WIDTH];
    end
  end

  always_comb begin
    state_d = state_q;
    done_d  = done_q;
    case (state_q)
      WR_IDLE: begin
        if (wr_valid_i) begin
          state_d = WR_ISSUE;
          done_d  = '0;
        end
      end
      WR_ISSUE: begin
        // A lane is finished on its grant
        done_d = done_q | (wr_bus.req & wr_bus.gnt);
        if (&done_d) begin
          state_d = WR_RESP;
        end
      end
      WR_RESP: begin
        if (wr_bready_i) begin
          state_d = WR_IDLE;
        end
      end
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= WR_IDLE;
      done_q  <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  // Write payload, loaded on the accept edge
  always_ff @(posedge clk_i) begin
    if (wr_valid_i && wr_ready_o) begin
      addr_q <= wr_addr_i;
      data_q <= wr_data_i;
      strb_q <= wr_strb_i;
    end
  end

endmodule

//--- verilog/bank_xbar.sv
// Bank crossbar; shares the four banks between write and read unit and routes read data back
`timescale 1ns/1ps

module bank_xbar import bank_mem_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  bank_req_if.xbar                   wr_bus,
  bank_req_if.xbar                   rd_bus,
  output logic      [NUM_BANKS-1:0]  mem_req_o,
  input  logic      [NUM_BANKS-1:0]  mem_gnt_i,
  output mem_addr_t [NUM_BANKS-1:0]  mem_addr_o,
  output logic      [NUM_BANKS-1:0]  mem_we_o,
  output mem_data_t [NUM_BANKS-1:0]  mem_wdata_o,
  output mem_strb_t [NUM_BANKS-1:0]  mem_be_o,
  input  mem_data_t [NUM_BANKS-1:0]  mem_rdata_i
);

  // Per bank, which unit wants it and which one got it this cycle
  logic [NUM_BANKS-1:0] wr_want, rd_want;
  logic [NUM_BANKS-1:0] wr_take, rd_take;
  // Per bank, read data valid on mem_rdata_i
  logic [NUM_BANKS-1:0] ret_vld;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    owner_e                 sel, sel_q, owner_q;
    logic                   lock_q;
    logic [MEM_LATENCY-1:0] ret_q;

    // Only lane (b mod LANES) of a unit can target bank b
    assign wr_want[b] = wr_bus.req[b % LANES] && (wr_bus.bank_sel[b % LANES] == b);
    assign rd_want[b] = rd_bus.req[b % LANES] && (rd_bus.bank_sel[b % LANES] == b);

    // Lock-in while the bank stalls, otherwise alternate on conflict
    always_comb begin
      if (lock_q) begin
        sel = sel_q;
      end else if (wr_want[b] && rd_want[b]) begin
        sel = (owner_q == OWNER_WR) ? OWNER_RD : OWNER_WR;
      end else if (wr_want[b]) begin
        sel = OWNER_WR;
      end else begin
        sel = OWNER_RD;
      end
    end

    assign mem_req_o[b]   = (sel == OWNER_WR) ? wr_want[b] : rd_want[b];
    assign mem_addr_o[b]  = (sel == OWNER_WR) ? wr_bus.addr[b % LANES] : rd_bus.addr[b % LANES];
    assign mem_we_o[b]    = (sel == OWNER_WR) ? wr_bus.we[b % LANES] : rd_bus.we[b % LANES];
    assign mem_wdata_o[b] = (sel == OWNER_WR) ? wr_bus.wdata[b % LANES] : rd_bus.wdata[b % LANES];
    assign mem_be_o[b]    = (sel == OWNER_WR) ? wr_bus.strb[b % LANES] : rd_bus.strb[b % LANES];

    assign wr_take[b] = mem_req_o[b] && mem_gnt_i[b] && (sel == OWNER_WR);
    assign rd_take[b] = mem_req_o[b] && mem_gnt_i[b] && (sel == OWNER_RD);

    // Oldest stage of the return pipe
    assign ret_vld[b] = ret_q[MEM_LATENCY-1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        lock_q  <= 1'b0;
        sel_q   <= OWNER_RD;
        owner_q <= OWNER_RD;
        ret_q   <= '0;
      end else begin
        lock_q <= mem_req_o[b] && !mem_gnt_i[b];
        sel_q  <= sel;
        // Owner moves only when both units competed
        if (wr_want[b] && rd_want[b] && mem_req_o[b] && mem_gnt_i[b]) begin
          owner_q <= sel;
        end
        // Read grants travel MEM_LATENCY cycles
        ret_q <= MEM_LATENCY'({ret_q, rd_take[b]});
      end
    end
  end

  // Fold bank grants and returns back onto the lanes
  always_comb begin
    wr_bus.gnt    = '0;
    rd_bus.gnt    = '0;
    rd_bus.rvalid = '0;
    rd_bus.rdata  = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (wr_take[b]) begin
        wr_bus.gnt[b % LANES] = 1'b1;
      end
      if (rd_take[b]) begin
        rd_bus.gnt[b % LANES] = 1'b1;
      end
      if (ret_vld[b]) begin
        rd_bus.rvalid[b % LANES] = 1'b1;
        rd_bus.rdata[b % LANES]  = mem_rdata_i[b];
      end
    end
  end

  // Writes get no data back
  assign wr_bus.rvalid = '0;
  assign wr_bus.rdata  = '0;

endmodule
